// ==== verilog/ccd_settings.svh ====
/*
  Camera front end build settings
  Sample, size and bus widths, line buffer depth, register map
  and the CTRL bit positions shared by the RTL and the testbench
*/
`ifndef CCD_SETTINGS_SVH
`define CCD_SETTINGS_SVH

// ==========================================================================
// Data path widths
// ==========================================================================
`define CCD_RAW_W       12      // Sensor sample
`define CCD_DIM_W       12      // Width, height and positions
`define CCD_MAX_WIDTH   1280    // Line buffer depth in samples
`define CCD_PIX_W       16      // Packed output pixel
`define CCD_COMP_BITS   5       // Bits kept per colour

// ==========================================================================
// APB register map
// ==========================================================================
`define CCD_WORD_W      32
`define CCD_ADDR_W      8
`define CCD_ADDR_CTRL   8'h00
`define CCD_ADDR_WIDTH  8'h04
`define CCD_ADDR_HEIGHT 8'h08
`define CCD_ADDR_FRAMES 8'h0C
`define CCD_ADDR_PIXELS 8'h10
`define CCD_ADDR_STATUS 8'h14

// CTRL bits
`define CCD_CTRL_START  0
`define CCD_CTRL_EN_R   1
`define CCD_CTRL_EN_G   2
`define CCD_CTRL_EN_B   3

`endif

// ==== verilog/ccd_pkg.sv ====
/*
  Camera front end types
  Sample, size, pixel and register word types, the register
  address map and the capture FSM states
*/
`include "ccd_settings.svh"

package ccd_pkg;

  typedef logic [`CCD_RAW_W-1:0]  raw_t;      // One Bayer sample
  typedef logic [`CCD_DIM_W-1:0]  dim_t;      // Size or position
  typedef logic [`CCD_PIX_W-1:0]  pixel_t;    // Packed RGB word
  typedef logic [`CCD_WORD_W-1:0] reg_word_t; // APB data

  // Register byte addresses
  typedef enum logic [`CCD_ADDR_W-1:0] {
    REG_CTRL   = `CCD_ADDR_CTRL,
    REG_WIDTH  = `CCD_ADDR_WIDTH,
    REG_HEIGHT = `CCD_ADDR_HEIGHT,
    REG_FRAMES = `CCD_ADDR_FRAMES,   // Read only
    REG_PIXELS = `CCD_ADDR_PIXELS,   // Read only
    REG_STATUS = `CCD_ADDR_STATUS    // Read only
  } reg_addr_e;

  // Frame gating states
  typedef enum logic [1:0] {
    CAP_IDLE,         // Start clear
    CAP_WAIT_FRAME,   // Armed, waiting for fval rise
    CAP_ACTIVE        // Inside a captured frame
  } capture_state_e;

endpackage

// ==== verilog/ccd_reg_decode.sv ====
/*
  APB register block for the camera front end
  Zero wait state slave holding CTRL, WIDTH and HEIGHT and
  returning the frame and pixel counters and the capture status
*/
`include "ccd_settings.svh"

module ccd_reg_decode (
  input  logic                    ccd_pixel_clk,
  input  logic                    rst_n,
  input  logic [`CCD_ADDR_W-1:0]  paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  ccd_pkg::reg_word_t      pwdata,
  input  ccd_pkg::reg_word_t      frame_count,
  input  ccd_pkg::reg_word_t      pixel_count,
  input  logic                    busy,
  output ccd_pkg::reg_word_t      prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    start,
  output logic [2:0]              chan_en,
  output ccd_pkg::dim_t           width,
  output ccd_pkg::dim_t           height
);

  localparam int CTRL_W = 4;               // Start plus three enables

  logic [CTRL_W-1:0]   ctrl_q;
  ccd_pkg::dim_t       width_q;
  ccd_pkg::dim_t       height_q;
  ccd_pkg::reg_word_t  rd_data;
  logic                access;
  logic                addr_ok;            // Address is in the map
  logic                ro_reg;             // Address is a read-only register
  logic                bad_access;
  logic                wr_en;

  // ==========================================================================
  // Address decode and read mux
  // ==========================================================================
  assign access = psel & penable;          // Access phase

  always_comb begin
    rd_data = '0;
    addr_ok = 1'b1;
    ro_reg  = 1'b0;
    case (paddr)
      ccd_pkg::REG_CTRL:   rd_data = ccd_pkg::reg_word_t'(ctrl_q);
      ccd_pkg::REG_WIDTH:  rd_data = ccd_pkg::reg_word_t'(width_q);
      ccd_pkg::REG_HEIGHT: rd_data = ccd_pkg::reg_word_t'(height_q);
      ccd_pkg::REG_FRAMES: begin
        rd_data = frame_count;
        ro_reg  = 1'b1;
      end
      ccd_pkg::REG_PIXELS: begin
        rd_data = pixel_count;
        ro_reg  = 1'b1;
      end
      ccd_pkg::REG_STATUS: begin
        rd_data = ccd_pkg::reg_word_t'(busy);   // Bit 0 only
        ro_reg  = 1'b1;
      end
      default: addr_ok = 1'b0;
    endcase
  end

  // Unmapped address or write to a read-only register
  assign bad_access = ~addr_ok | (pwrite & ro_reg);
  assign wr_en      = access & pwrite & ~bad_access;

  assign pready  = 1'b1;                   // No wait states
  assign pslverr = access & bad_access;
  assign prdata  = (access & ~pwrite & addr_ok) ? rd_data : '0;

  // ==========================================================================
  // Read-write registers
  // ==========================================================================
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q   <= '0;
      width_q  <= '0;
      height_q <= '0;
    end else if (wr_en) begin
      if (paddr == ccd_pkg::REG_CTRL) begin
        ctrl_q <= pwdata[CTRL_W-1:0];
      end
      if (paddr == ccd_pkg::REG_WIDTH) begin
        width_q <= pwdata[`CCD_DIM_W-1:0];
      end
      if (paddr == ccd_pkg::REG_HEIGHT) begin
        height_q <= pwdata[`CCD_DIM_W-1:0];
      end
    end
  end

  // Control fields out to the datapath
  assign start   = ctrl_q[`CCD_CTRL_START];
  assign chan_en = {ctrl_q[`CCD_CTRL_EN_B],   // Bit 2 blue
                    ctrl_q[`CCD_CTRL_EN_G],   // Bit 1 green
                    ctrl_q[`CCD_CTRL_EN_R]};  // Bit 0 red
  assign width   = width_q;
  assign height  = height_q;

endmodule

// ==== verilog/ccd_capture.sv ====
/*
  Sensor capture engine
  Registers the Bayer samples and strobes, gates whole frames
  on fval edges, crops to the programmed window and counts frames
*/
module ccd_capture (
  input  logic               ccd_pixel_clk,
  input  logic               rst_n,
  input  ccd_pkg::raw_t      ccd_data,
  input  logic               ccd_fval,
  input  logic               ccd_lval,
  input  logic               start,
  input  ccd_pkg::dim_t      width,
  input  ccd_pkg::dim_t      height,
  output ccd_pkg::raw_t      cap_data,
  output logic               cap_valid,
  output ccd_pkg::dim_t      cap_x,
  output ccd_pkg::dim_t      cap_y,
  output logic               frame_done,
  output ccd_pkg::reg_word_t frame_count,
  output logic               busy
);

  ccd_pkg::raw_t            data_r;
  logic                     fval_r, lval_r;     // Input stage
  logic                     fval_d, lval_d;     // Previous cycle, for edges
  logic                     fval_rise, fval_fall, lval_fall;
  ccd_pkg::capture_state_e  state;
  ccd_pkg::dim_t            x_cnt, y_cnt;
  logic                     in_frame;
  logic                     in_window;

  // ==========================================================================
  // Input register and edge detect
  // ==========================================================================
  always_ff @(posedge ccd_pixel_clk) begin
    data_r <= ccd_data;
  end

  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      fval_r <= 1'b0;
      lval_r <= 1'b0;
      fval_d <= 1'b0;
      lval_d <= 1'b0;
    end else begin
      fval_r <= ccd_fval;
      lval_r <= ccd_lval;
      fval_d <= fval_r;
      lval_d <= lval_r;
    end
  end

  assign fval_rise = fval_r & ~fval_d;
  assign fval_fall = ~fval_r & fval_d;
  assign lval_fall = ~lval_r & lval_d;    // End of a line

  // ==========================================================================
  // Frame gating FSM
  // ==========================================================================
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ccd_pkg::CAP_IDLE;
      frame_done  <= 1'b0;
      frame_count <= '0;
    end else begin
      frame_done <= 1'b0;
      case (state)
        ccd_pkg::CAP_IDLE: begin
          if (start) state <= ccd_pkg::CAP_WAIT_FRAME;
        end
        ccd_pkg::CAP_WAIT_FRAME: begin
          if (!start)         state <= ccd_pkg::CAP_IDLE;   // Disarm before frame
          else if (fval_rise) state <= ccd_pkg::CAP_ACTIVE;
        end
        ccd_pkg::CAP_ACTIVE: begin
          // A started frame always runs to its end
          if (fval_fall) begin
            frame_done  <= 1'b1;
            frame_count <= frame_count + 1'b1;
            state       <= start ? ccd_pkg::CAP_WAIT_FRAME : ccd_pkg::CAP_IDLE;
          end
        end
        default: state <= ccd_pkg::CAP_IDLE;
      endcase
    end
  end

  assign busy = (state == ccd_pkg::CAP_ACTIVE);

  // First cycle of a frame counts as captured too
  assign in_frame = busy | ((state == ccd_pkg::CAP_WAIT_FRAME) & start & fval_rise);

  // ==========================================================================
  // Position counters and window crop
  // ==========================================================================
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      x_cnt <= '0;
      y_cnt <= '0;
    end else begin
      if (lval_r & fval_r) begin
        if (x_cnt != '1) x_cnt <= x_cnt + 1'b1;   // Saturate on long lines
      end else begin
        x_cnt <= '0;                              // Column restarts per line
      end
      if (fval_rise | ~fval_r) begin
        y_cnt <= '0;                              // Row restarts per frame
      end else if (lval_fall && y_cnt != '1) begin
        y_cnt <= y_cnt + 1'b1;
      end
    end
  end

  assign in_window = (x_cnt < width) & (y_cnt < height);

  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) cap_valid <= 1'b0;
    else        cap_valid <= lval_r & fval_r & in_frame & in_window;
  end

  // Sample and its position, qualified by cap_valid
  always_ff @(posedge ccd_pixel_clk) begin
    cap_data <= data_r;
    cap_x    <= x_cnt;
    cap_y    <= y_cnt;
  end

endmodule

// ==== verilog/bayer_demosaic.sv ====
/*
  Bayer to RGB conversion at half resolution
  Even rows go into a one-line buffer; each odd-row, odd-column
  sample closes a 2x2 cell and produces one RGB pixel
*/
`include "ccd_settings.svh"

module bayer_demosaic (
  input  logic           ccd_pixel_clk,
  input  logic           rst_n,
  input  ccd_pkg::raw_t  cap_data,
  input  logic           cap_valid,
  input  ccd_pkg::dim_t  cap_x,
  input  ccd_pkg::dim_t  cap_y,
  output ccd_pkg::raw_t  red,
  output ccd_pkg::raw_t  green,
  output ccd_pkg::raw_t  blue,
  output logic           rgb_valid
);

  // Cell layout
  //   even row   G1 R
  //   odd row    B  G2

  localparam int BUF_AW = $clog2(`CCD_MAX_WIDTH);

  ccd_pkg::raw_t      line_buf [`CCD_MAX_WIDTH];   // Previous even row
  logic [BUF_AW-1:0]  buf_addr;
  logic               buf_hit;                     // Column fits the buffer
  ccd_pkg::raw_t      buf_rd;
  ccd_pkg::raw_t      prev_sample;                 // B of the current cell
  ccd_pkg::raw_t      g1_hold;                     // G1 fetched one cycle early
  logic [`CCD_RAW_W:0] g_sum;                      // 13 bit G1 + G2
  logic               odd_row, odd_col;
  logic               cell_end;

  assign odd_row  = cap_y[0];
  assign odd_col  = cap_x[0];
  assign buf_addr = cap_x[BUF_AW-1:0];
  assign buf_hit  = (cap_x < `CCD_MAX_WIDTH);
  assign buf_rd   = line_buf[buf_addr];            // Same column, row above
  assign cell_end = cap_valid & odd_row & odd_col; // G2 closes the cell

  // ==========================================================================
  // Line buffer
  // ==========================================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (cap_valid & ~odd_row & buf_hit) begin
      line_buf[buf_addr] <= cap_data;              // G1 or R
    end
  end

  // Odd row, even column holds B here and G1 from the buffer
  always_ff @(posedge ccd_pixel_clk) begin
    if (cap_valid & odd_row & ~odd_col) begin
      prev_sample <= cap_data;
      g1_hold     <= buf_rd;
    end
  end

  // ==========================================================================
  // Pixel output
  // ==========================================================================
  assign g_sum = {1'b0, g1_hold} + {1'b0, cap_data};   // Full sum, no overflow

  always_ff @(posedge ccd_pixel_clk) begin
    if (cell_end) begin
      red   <= buf_rd;                 // R sits above G2
      green <= g_sum[`CCD_RAW_W:1];    // Average of both greens
      blue  <= prev_sample;
    end
  end

  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) rgb_valid <= 1'b0;
    else        rgb_valid <= cell_end;
  end

endmodule

// ==== verilog/pixel_pack.sv ====
/*
  RGB packer and pixel counter
  Builds the 16 bit word of one zero bit and 5 bits per colour,
  masks disabled channels and counts pixels per frame
*/
`include "ccd_settings.svh"

module pixel_pack (
  input  logic               ccd_pixel_clk,
  input  logic               rst_n,
  input  ccd_pkg::raw_t      red,
  input  ccd_pkg::raw_t      green,
  input  ccd_pkg::raw_t      blue,
  input  logic               rgb_valid,
  input  logic [2:0]         chan_en,       // Blue, green, red
  input  logic               frame_done,
  output ccd_pkg::pixel_t    pix_data,
  output logic               pix_valid,
  output ccd_pkg::reg_word_t pixel_count
);

  logic [`CCD_COMP_BITS-1:0] r_field, g_field, b_field;
  ccd_pkg::reg_word_t        pix_cnt;       // Running count of this frame

  // Top bits of each colour, zero when masked
  assign r_field = chan_en[0] ? red[`CCD_RAW_W-1 -: `CCD_COMP_BITS]   : '0;
  assign g_field = chan_en[1] ? green[`CCD_RAW_W-1 -: `CCD_COMP_BITS] : '0;
  assign b_field = chan_en[2] ? blue[`CCD_RAW_W-1 -: `CCD_COMP_BITS]  : '0;

  always_ff @(posedge ccd_pixel_clk) begin
    if (rgb_valid) pix_data <= {1'b0, r_field, g_field, b_field};
  end

  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) pix_valid <= 1'b0;
    else        pix_valid <= rgb_valid;
  end

  // ==========================================================================
  // Per-frame pixel count
  // ==========================================================================
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_cnt     <= '0;
      pixel_count <= '0;
    end else if (frame_done) begin
      pixel_count <= pix_cnt + rgb_valid;   // Include a pixel on the same edge
      pix_cnt     <= '0;
    end else if (rgb_valid) begin
      pix_cnt <= pix_cnt + 1'b1;
    end
  end

endmodule

// ==== verilog/ccd_camera_top.sv ====
/*
  Camera front end top level
  APB register block, capture, demosaic and packing on the pixel clock
*/
`include "ccd_settings.svh"

module ccd_camera_top (
  input  logic                    ccd_pixel_clk,
  input  logic                    rst_n,
  // APB slave
  input  logic [`CCD_ADDR_W-1:0]  paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  ccd_pkg::reg_word_t      pwdata,
  output ccd_pkg::reg_word_t      prdata,
  output logic                    pready,
  output logic                    pslverr,
  // Sensor
  input  ccd_pkg::raw_t           ccd_data,
  input  logic                    ccd_fval,
  input  logic                    ccd_lval,
  // Pixel stream
  output ccd_pkg::pixel_t         pix_data,
  output logic                    pix_valid
);

  logic               start;
  logic [2:0]         chan_en;
  ccd_pkg::dim_t      width, height;        // Crop window
  ccd_pkg::raw_t      cap_data;
  logic               cap_valid;
  ccd_pkg::dim_t      cap_x, cap_y;
  logic               frame_done;
  ccd_pkg::reg_word_t frame_count;
  ccd_pkg::reg_word_t pixel_count;
  logic               busy;
  ccd_pkg::raw_t      red, green, blue;
  logic               rgb_valid;

  ccd_reg_decode u_reg_decode (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst_n         (rst_n),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .frame_count   (frame_count),
    .pixel_count   (pixel_count),
    .busy          (busy),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .start         (start),
    .chan_en       (chan_en),
    .width         (width),
    .height        (height)
  );

  // Two cycles from port to cap_valid
  ccd_capture u_capture (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst_n         (rst_n),
    .ccd_data      (ccd_data),
    .ccd_fval      (ccd_fval),
    .ccd_lval      (ccd_lval),
    .start         (start),
    .width         (width),
    .height        (height),
    .cap_data      (cap_data),
    .cap_valid     (cap_valid),
    .cap_x         (cap_x),
    .cap_y         (cap_y),
    .frame_done    (frame_done),
    .frame_count   (frame_count),
    .busy          (busy)
  );

  bayer_demosaic u_demosaic (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst_n         (rst_n),
    .cap_data      (cap_data),
    .cap_valid     (cap_valid),
    .cap_x         (cap_x),
    .cap_y         (cap_y),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .rgb_valid     (rgb_valid)
  );

  pixel_pack u_pack (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst_n         (rst_n),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .rgb_valid     (rgb_valid),
    .chan_en       (chan_en),
    .frame_done    (frame_done),
    .pix_data      (pix_data),
    .pix_valid     (pix_valid),
    .pixel_count   (pixel_count)
  );

endmodule

// ==== testbench/tb_ccd_tasks.svh ====
/*
  Camera front end testbench tasks
  APB access, sensor frames, LFSR samples, reference model,
  compare tasks and the directed tests
*/
`ifndef TB_CCD_TASKS_SVH
`define TB_CCD_TASKS_SVH

// ============================================================================
// Compare tasks
// ============================================================================
task automatic check_pixel(input string name, input ccd_pkg::pixel_t expected,
                           input ccd_pkg::pixel_t actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("** Error %s: expected %h, actual %h", name, expected, actual);
  end
endtask

task automatic check_word(input string name, input ccd_pkg::reg_word_t expected,
                          input ccd_pkg::reg_word_t actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("** Error %s: expected %h, actual %h", name, expected, actual);
  end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("** Error %s: expected %b, actual %b", name, expected, actual);
  end
endtask

task automatic report_test(input string name, input int errs_before);
  tests_run++;
  if (error_count > errs_before) begin
    tests_failed++;
    $display("[%s] failed with %0d errors", name, error_count - errs_before);
  end else begin
    $display("[%s] ok", name);
  end
endtask

// ============================================================================
// APB master
// ============================================================================
task automatic apb_transfer(input logic wr, input logic [`CCD_ADDR_W-1:0] addr,
                            input ccd_pkg::reg_word_t wdata);
  @(posedge ccd_pixel_clk);
  paddr   <= addr;                         // Setup phase
  pwrite  <= wr;
  pwdata  <= wdata;
  psel    <= 1'b1;
  penable <= 1'b0;
  @(posedge ccd_pixel_clk);
  penable <= 1'b1;                         // Access phase
  @(negedge ccd_pixel_clk);
  if (!pready) begin
    error_count++;
    $display("APB slave held pready low in the access phase at address %h", addr);
  end
  last_rdata = prdata;                     // Stable mid-cycle
  last_err   = pslverr;
  @(posedge ccd_pixel_clk);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task automatic apb_write(input logic [`CCD_ADDR_W-1:0] addr, input ccd_pkg::reg_word_t data);
  apb_transfer(1'b1, addr, data);
endtask

task automatic apb_read(input logic [`CCD_ADDR_W-1:0] addr, output ccd_pkg::reg_word_t data);
  apb_transfer(1'b0, addr, '0);
  data = last_rdata;
endtask

task automatic program_capture(input int w, input int h, input logic [3:0] ctrl);
  apb_write(ccd_pkg::REG_WIDTH, w);
  apb_write(ccd_pkg::REG_HEIGHT, h);
  apb_write(ccd_pkg::REG_CTRL, ctrl);      // {blue, green, red, start}
endtask

// Poll FRAMES until it reaches the target
task automatic wait_frames(input string name, input int target);
  ccd_pkg::reg_word_t rd;
  int polls;
  rd    = '0;
  polls = 0;
  while (rd != target && polls < FRAME_POLLS) begin
    apb_read(ccd_pkg::REG_FRAMES, rd);
    polls++;
  end
  if (rd != target) begin
    error_count++;
    $display("%s: frame counter stuck at %0d, expected %0d", name, rd, target);
  end
endtask

// ============================================================================
// Sensor side and stimulus
// ============================================================================
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
endfunction

function automatic ccd_pkg::raw_t random_sample();
  ccd_pkg::raw_t v;
  v = '0;
  for (int i = 0; i < `CCD_RAW_W; i++) begin
    lfsr_q = lfsr_next(lfsr_q);            // One step per bit
    v      = {v[`CCD_RAW_W-2:0], lfsr_q[0]};
  end
  return v;
endfunction

task automatic fill_frame(input int lines, input int cols);
  for (int r = 0; r < lines; r++) begin
    for (int c = 0; c < cols; c++) begin
      frame_mem[r][c] = random_sample();
    end
  end
endtask

task automatic send_frame(input int lines, input int cols);
  @(posedge ccd_pixel_clk);
  ccd_fval <= 1'b1;
  repeat (2) @(posedge ccd_pixel_clk);     // Lead-in before first line
  for (int r = 0; r < lines; r++) begin
    for (int c = 0; c < cols; c++) begin
      @(posedge ccd_pixel_clk);
      ccd_lval <= 1'b1;
      ccd_data <= frame_mem[r][c];
    end
    @(posedge ccd_pixel_clk);
    ccd_lval <= 1'b0;
    ccd_data <= '0;
    repeat (LINE_GAP - 1) @(posedge ccd_pixel_clk);
  end
  repeat (FRAME_TAIL) @(posedge ccd_pixel_clk);   // Pipeline drains first
  ccd_fval <= 1'b0;
  repeat (4) @(posedge ccd_pixel_clk);
endtask

task automatic monitor_pixels();
  forever begin
    @(negedge ccd_pixel_clk);
    if (pix_valid) pix_q.push_back(pix_data);
  end
endtask

// ============================================================================
// Reference model
// ============================================================================
function automatic ccd_pkg::pixel_t expected_pixel(input ccd_pkg::raw_t g1, r, b, g2,
                                                   input logic [2:0] en);
  logic [`CCD_RAW_W:0] g_sum;
  ccd_pkg::raw_t g;
  g_sum = {1'b0, g1} + {1'b0, g2};
  g     = g_sum[`CCD_RAW_W:1];             // Mean of both greens
  return {1'b0,
          en[0] ? r[`CCD_RAW_W-1 -: `CCD_COMP_BITS] : 5'd0,
          en[1] ? g[`CCD_RAW_W-1 -: `CCD_COMP_BITS] : 5'd0,
          en[2] ? b[`CCD_RAW_W-1 -: `CCD_COMP_BITS] : 5'd0};
endfunction

task automatic model_frame(input int w, input int h, input int lines, input int cols,
                           input logic [2:0] en);
  int ew, eh;
  ew = (w < cols) ? w : cols;              // Crop window inside the frame
  eh = (h < lines) ? h : lines;
  for (int r = 0; r + 1 < eh; r += 2) begin
    for (int c = 0; c + 1 < ew; c += 2) begin
      exp_q.push_back(expected_pixel(frame_mem[r][c], frame_mem[r][c+1],
                                     frame_mem[r+1][c], frame_mem[r+1][c+1], en));
    end
  end
endtask

task automatic compare_pixels(input string name);
  check_word({name, " pixel count"}, exp_q.size(), pix_q.size());
  while (exp_q.size() > 0 && pix_q.size() > 0) begin
    check_pixel({name, " pixel"}, exp_q.pop_front(), pix_q.pop_front());
  end
  exp_q.delete();
  pix_q.delete();
endtask

// ============================================================================
// Directed tests
// ============================================================================
task automatic run_register_checks();
  string name;
  int errs;
  ccd_pkg::reg_word_t rd;
  name = "registers";
  errs = error_count;
  apb_read(ccd_pkg::REG_CTRL, rd);
  check_word({name, " CTRL reset"}, 0, rd);
  apb_read(ccd_pkg::REG_WIDTH, rd);
  check_word({name, " WIDTH reset"}, 0, rd);
  apb_read(ccd_pkg::REG_HEIGHT, rd);
  check_word({name, " HEIGHT reset"}, 0, rd);
  apb_read(ccd_pkg::REG_FRAMES, rd);
  check_word({name, " FRAMES reset"}, 0, rd);
  apb_read(ccd_pkg::REG_PIXELS, rd);
  check_word({name, " PIXELS reset"}, 0, rd);
  apb_read(ccd_pkg::REG_STATUS, rd);
  check_word({name, " STATUS reset"}, 0, rd);
  apb_write(ccd_pkg::REG_CTRL, 32'hE);     // Enables only with start clear
  check_flag({name, " CTRL write pslverr"}, 1'b0, last_err);
  apb_write(ccd_pkg::REG_WIDTH, 32'h123);
  apb_write(ccd_pkg::REG_HEIGHT, 32'h2BC);
  apb_read(ccd_pkg::REG_CTRL, rd);
  check_word({name, " CTRL readback"}, 32'hE, rd);
  apb_read(ccd_pkg::REG_WIDTH, rd);
  check_word({name, " WIDTH readback"}, 32'h123, rd);
  apb_read(ccd_pkg::REG_HEIGHT, rd);
  check_word({name, " HEIGHT readback"}, 32'h2BC, rd);
  apb_read(8'h18, rd);                     // Unmapped
  check_flag({name, " unmapped pslverr"}, 1'b1, last_err);
  check_word({name, " unmapped data"}, 0, rd);
  apb_write(ccd_pkg::REG_FRAMES, 32'h55);
  check_flag({name, " FRAMES write pslverr"}, 1'b1, last_err);
  apb_read(ccd_pkg::REG_FRAMES, rd);
  check_word({name, " FRAMES unchanged"}, 0, rd);
  report_test(name, errs);
endtask

task automatic demosaic_4x4();
  string name;
  int errs;
  ccd_pkg::reg_word_t rd;
  name = "demosaic";
  errs = error_count;
  program_capture(4, 4, 4'hF);
  fill_frame(4, 4);
  model_frame(4, 4, 4, 4, 3'b111);
  send_frame(4, 4);
  frames_exp++;
  wait_frames(name, frames_exp);
  compare_pixels(name);
  apb_read(ccd_pkg::REG_PIXELS, rd);
  check_word({name, " PIXELS"}, 4, rd);
  report_test(name, errs);
endtask

task automatic crop_window();
  string name;
  int errs;
  ccd_pkg::reg_word_t rd;
  name = "crop";
  errs = error_count;
  program_capture(4, 2, 4'hF);
  fill_frame(6, 8);
  model_frame(4, 2, 6, 8, 3'b111);         // Top-left cells only
  send_frame(6, 8);
  frames_exp++;
  wait_frames(name, frames_exp);
  compare_pixels(name);
  apb_read(ccd_pkg::REG_PIXELS, rd);
  check_word({name, " PIXELS"}, 2, rd);
  report_test(name, errs);
endtask

task automatic mask_channels();
  string name;
  int errs;
  name = "masks";
  errs = error_count;
  program_capture(4, 4, 4'hB);             // Green off
  fill_frame(4, 4);
  model_frame(4, 4, 4, 4, 3'b101);
  send_frame(4, 4);
  frames_exp++;
  wait_frames(name, frames_exp);
  compare_pixels({name, " no green"});
  apb_write(ccd_pkg::REG_CTRL, 32'h5);     // Green only
  fill_frame(4, 4);
  model_frame(4, 4, 4, 4, 3'b010);
  send_frame(4, 4);
  frames_exp++;
  wait_frames(name, frames_exp);
  compare_pixels({name, " green only"});
  report_test(name, errs);
endtask

task automatic start_stop_sync();
  string name;
  int errs;
  ccd_pkg::reg_word_t rd;
  ccd_pkg::reg_word_t status;
  name = "start stop";
  errs = error_count;
  apb_write(ccd_pkg::REG_CTRL, 32'hE);     // Start clear
  fill_frame(4, 4);
  send_frame(4, 4);
  apb_read(ccd_pkg::REG_FRAMES, rd);
  check_word({name, " FRAMES idle"}, frames_exp, rd);
  check_word({name, " pixels idle"}, 0, pix_q.size());

  // Start arrives mid-frame and this frame is skipped
  fill_frame(4, 4);
  fork
    send_frame(4, 4);
    begin
      while (!ccd_fval) @(posedge ccd_pixel_clk);
      apb_write(ccd_pkg::REG_CTRL, 32'hF);
    end
  join
  apb_read(ccd_pkg::REG_FRAMES, rd);
  check_word({name, " FRAMES skipped"}, frames_exp, rd);
  check_word({name, " pixels skipped"}, 0, pix_q.size());

  fill_frame(4, 4);
  model_frame(4, 4, 4, 4, 3'b111);
  fork
    send_frame(4, 4);
    begin
      while (!ccd_lval) @(posedge ccd_pixel_clk);
      apb_read(ccd_pkg::REG_STATUS, status);
    end
  join
  check_word({name, " STATUS active"}, 1, status);
  frames_exp++;
  wait_frames(name, frames_exp);
  compare_pixels(name);
  apb_read(ccd_pkg::REG_PIXELS, rd);
  check_word({name, " PIXELS"}, 4, rd);
  report_test(name, errs);
endtask

`endif

// ==== testbench/tb_ccd_camera.sv ====
/*
  Testbench top for the camera front end
  Clock, reset, DUT, stimulus LFSR, pixel monitor, watchdog
  and the directed test sequence
*/
`include "ccd_settings.svh"

module tb_ccd_camera;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int FRAME_POLLS  = 16;          // FRAMES reads before giving up
  localparam int LINE_GAP     = 4;           // Idle cycles between lines
  localparam int FRAME_TAIL   = 6;           // Idle cycles before fval falls
  localparam int MAX_DIM      = 16;          // Largest test frame

  // ==========================================================================
  // Test lengths in clock cycles for the watchdog
  // ==========================================================================
  localparam int LEN_REGS     = 80;
  localparam int LEN_DEMOSAIC = 100;
  localparam int LEN_CROP     = 120;
  localparam int LEN_MASK     = 150;
  localparam int LEN_START    = 220;
  localparam int TEST_CYCLES  = RESET_CYCLES + LEN_REGS + LEN_DEMOSAIC + LEN_CROP
                              + LEN_MASK + LEN_START;
  localparam int WATCHDOG_NS  = TEST_CYCLES * 2 * CLK_PERIOD;

  logic                    ccd_pixel_clk = 1'b0;
  logic                    rst_n;
  logic [`CCD_ADDR_W-1:0]  paddr;
  logic                    psel, penable, pwrite;
  ccd_pkg::reg_word_t      pwdata, prdata;
  logic                    pready, pslverr;
  ccd_pkg::raw_t           ccd_data;
  logic                    ccd_fval, ccd_lval;
  ccd_pkg::pixel_t         pix_data;
  logic                    pix_valid;

  // Scoreboard state
  ccd_pkg::pixel_t         pix_q[$];         // Seen at the DUT output
  ccd_pkg::pixel_t         exp_q[$];         // From the model
  ccd_pkg::raw_t           frame_mem [MAX_DIM][MAX_DIM];
  logic [15:0]             lfsr_q;
  ccd_pkg::reg_word_t      last_rdata;
  logic                    last_err;
  int                      error_count  = 0;
  int                      check_count  = 0;
  int                      tests_run    = 0;
  int                      tests_failed = 0;
  int                      frames_exp   = 0;   // Expected FRAMES value

  always #(CLK_PERIOD / 2) ccd_pixel_clk = ~ccd_pixel_clk;

  ccd_camera_top u_dut (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst_n         (rst_n),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .ccd_data      (ccd_data),
    .ccd_fval      (ccd_fval),
    .ccd_lval      (ccd_lval),
    .pix_data      (pix_data),
    .pix_valid     (pix_valid)
  );

  `include "tb_ccd_tasks.svh"

  // Hang guard at twice the expected run length
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    rst_n    = 1'b0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    ccd_data = '0;
    ccd_fval = 1'b0;
    ccd_lval = 1'b0;
    lfsr_q   = 16'd65;                       // Seed
    repeat (RESET_CYCLES) @(posedge ccd_pixel_clk);
    rst_n <= 1'b1;
    fork
      monitor_pixels();
    join_none

    run_register_checks();
    demosaic_4x4();
    crop_window();
    mask_channels();
    start_stop_sync();

    $display("Tests %0d run, %0d failed; checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+verilog
+incdir+testbench
verilog/ccd_pkg.sv
verilog/ccd_reg_decode.sv
verilog/ccd_capture.sv
verilog/bayer_demosaic.sv
verilog/pixel_pack.sv
verilog/ccd_camera_top.sv
testbench/tb_ccd_camera.sv

// ==== Bender.yml ====
package:
  name: ccd_camera

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ccd_pkg.sv
      - verilog/ccd_reg_decode.sv
      - verilog/ccd_capture.sv
      - verilog/bayer_demosaic.sv
      - verilog/pixel_pack.sv
      - verilog/ccd_camera_top.sv
  - target: test
    include_dirs:
      - verilog
      - testbench
    files:
      - testbench/tb_ccd_camera.sv
